//--- Bender.yml
package:
  name: eeprom_ctrl

sources:
  - logic/i2c_line_pkg.sv
  - logic/eeprom_host_pkg.sv
  - logic/i2c_bit_engine.sv
  - logic/eeprom_seq.sv
  - logic/eeprom_ctrl_top.sv
  - target: simulation
    files:
      - dv/i2c_eeprom_model.sv
      - dv/eeprom_ctrl_asserts.sv
      - dv/eeprom_tb.sv

//--- build.f
logic/i2c_line_pkg.sv
logic/eeprom_host_pkg.sv
logic/i2c_bit_engine.sv
logic/eeprom_seq.sv
logic/eeprom_ctrl_top.sv
dv/i2c_eeprom_model.sv
dv/eeprom_ctrl_asserts.sv
dv/eeprom_tb.sv

//--- dv/eeprom_ctrl_asserts.sv
`timescale 1ns/10ps

module eeprom_ctrl_asserts
    import eeprom_host_pkg::*;
(
    input logic    CLK,
    input logic    RESET,
    input wb_req_t wb_req,
    input wb_rsp_t wb_rsp,
    input logic    scl,
    input logic    sda
);

    int unsigned fail_count = 0;

    ack_err_apart: assert property (@(posedge CLK) disable iff (RESET)
        !(wb_rsp.ack && wb_rsp.err))
    else
    begin
        $error("ack and err high in the same cycle");
        fail_count++;
    end

    rsp_in_cycle: assert property (@(posedge CLK) disable iff (RESET)
        (wb_rsp.ack || wb_rsp.err) |-> (wb_req.cyc && wb_req.stb))
    else
    begin
        $error("ack or err outside a bus cycle");
        fail_count++;
    end

    // bus idle right out of reset
    idle_after_reset: assert property (@(posedge CLK)
        $fell(RESET) |-> (scl && sda))
    else
    begin
        $error("scl or sda not idle after reset");
        fail_count++;
    end

endmodule

bind eeprom_ctrl_top eeprom_ctrl_asserts u_asserts (
    .CLK    (CLK),
    .RESET  (RESET),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .scl    (scl),
    .sda    (sda)
);

//--- dv/eeprom_input.txt
# columns are we adr dat refuse in hex
# a read compares dat and refuse 1 expects err
1 005 a5 0
0 005 a5 0
1 012 3c 0
1 712 c3 0
0 012 3c 0
0 712 c3 0
0 2f0 ff 0
1 100 55 1
0 100 ff 0
1 100 66 0
0 100 66 0
0 4c7 00 1
1 7ff 9e 0
0 7ff 9e 0
0 005 a5 0

//--- dv/eeprom_tb.sv
`timescale 1ns/10ps

module eeprom_tb
    import eeprom_host_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;

    logic    CLK;
    logic    RESET;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    refuse;
    wire     scl;
    wire     sda;
    integer  seed = 32'hc767_0c81;
    int      mismatches = 0;
    int      timeouts = 0;
    int      other_fails = 0;
    int      transfers = 0;

    pullup (sda);

    eeprom_ctrl_top u_eeprom_ctrl_top (
        .CLK    (CLK),
        .RESET  (RESET),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .scl    (scl),
        .sda    (sda)
    );

    i2c_eeprom_model u_model (
        .scl    (scl),
        .sda    (sda),
        .refuse (refuse)
    );

    initial
        CLK = 1'b0;
    always #20 CLK = ~CLK;

    task automatic report_mismatch(string name, logic [7:0] exp, logic [7:0] got);
        $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, got);
        mismatches++;
    endtask

    // bus must rest between transfers
    task automatic check_idle_lines(int cycles);
        repeat (cycles)
        begin
            @(negedge CLK);
            if (wb_rsp.ack !== 1'b0)
                report_mismatch("wb_rsp.ack", 8'h0, wb_rsp.ack);
            if (wb_rsp.err !== 1'b0)
                report_mismatch("wb_rsp.err", 8'h0, wb_rsp.err);
            if (scl !== 1'b1)
                report_mismatch("scl", 8'h1, scl);
            if (sda !== 1'b1)
                report_mismatch("sda", 8'h1, sda);
        end
    endtask

    task automatic run_transfer(logic we, logic [10:0] adr, logic [7:0] dat, logic refuse_on);
        int      waited;
        wb_rsp_t got;
        waited     = 0;
        refuse     = refuse_on;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = we ? dat : 8'h00;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        while (!(wb_rsp.ack || wb_rsp.err) && waited < TIMEOUT_CYCLES)
        begin
            @(negedge CLK);
            waited++;
        end
        got = wb_rsp;
        if (waited >= TIMEOUT_CYCLES)
        begin
            $display("timeout at %0t, no ack or err for address %03h", $time, adr);
            timeouts++;
        end
        else
        begin
            if (got.err !== refuse_on)
                report_mismatch("wb_rsp.err", refuse_on, got.err);
            if (got.ack !== !refuse_on)
                report_mismatch("wb_rsp.ack", !refuse_on, got.ack);
            if (!we && !refuse_on && got.dat !== dat)
                report_mismatch("wb_rsp.dat", dat, got.dat);
        end
        @(negedge CLK);
        if (wb_rsp.ack !== 1'b0 || wb_rsp.err !== 1'b0)
            report_mismatch("wb_rsp.ack/err", 8'h0, {wb_rsp.ack, wb_rsp.err});
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        refuse     = 1'b0;
    endtask

    initial
    begin
        int    fd;
        int    asserts;
        string line;
        int    we_col;
        int    adr_col;
        int    dat_col;
        int    refuse_col;
        RESET  = 1'b1;
        wb_req = '0;
        refuse = 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        check_idle_lines(8);
        fd = $fopen("dv/eeprom_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open dv/eeprom_input.txt");
            other_fails++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#" &&
                    $sscanf(line, "%h %h %h %h", we_col, adr_col, dat_col, refuse_col) == 4)
                begin
                    run_transfer(we_col[0], adr_col[10:0], dat_col[7:0], refuse_col[0]);
                    transfers++;
                    check_idle_lines(2 + int'($unsigned($random(seed)) % 6));
                end
            end
            $fclose(fd);
        end
        if (transfers == 0)
        begin
            $display("no transfers were read from the input file");
            other_fails++;
        end
        asserts = u_eeprom_ctrl_top.u_asserts.fail_count;
        $display("transfers %0d, mismatches %0d, timeouts %0d, other %0d, assertions %0d",
                 transfers, mismatches, timeouts, other_fails, asserts);
        if (mismatches + timeouts + other_fails + asserts == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- dv/i2c_eeprom_model.sv
`timescale 1ns/10ps

module i2c_eeprom_model
    import i2c_line_pkg::*;
    import eeprom_host_pkg::*;
(
    input logic scl,
    inout wire  sda,
    input logic refuse     // nack the address byte
);

    logic [7:0]           mem [EE_SIZE];
    logic [EE_ADDR_W-1:0] ptr;
    logic [2:0]           blk;
    logic [7:0]           sh;
    logic [7:0]           tx;
    i2c_byte_u            ctrl;
    int                   bit_cnt;    // scl rises seen in this byte
    int                   byte_idx;
    logic                 active;
    logic                 sending;
    logic                 keep;
    logic                 send_next;
    logic                 drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        foreach (mem[i])
            mem[i] = 8'hff;
        active    = 1'b0;
        sending   = 1'b0;
        keep      = 1'b0;
        send_next = 1'b0;
        bit_cnt   = 0;
        byte_idx  = 0;
        drive_low = 1'b0;
    end

    task automatic take_byte();
        logic ack;
        ack       = 1'b1;
        send_next = 1'b0;
        case (byte_idx)
            0:
            begin
                ctrl.raw  = sh;
                ack       = (ctrl.ctrl.dev_type == EE_DEV_TYPE);
                send_next = ctrl.ctrl.rw;
                if (!ctrl.ctrl.rw)
                    blk = ctrl.ctrl.block;
            end
            1:
            begin
                ack = !refuse;
                ptr = {blk, sh};
            end
            default:
            begin
                mem[ptr] = sh;    // no write cycle time
                ptr++;
            end
        endcase
        keep      = ack;
        byte_idx++;
        drive_low = ack;
    endtask

    // start or stop, looked at once the edge has settled
    always @(sda)
    begin
        #1;
        if (scl === 1'b1)
        begin
            active    = (sda === 1'b0);
            sending   = 1'b0;
            bit_cnt   = 0;
            byte_idx  = 0;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (bit_cnt < 8)
                sh = {sh[6:0], sda === 1'b1};
            else if (sending && sda !== 1'b0)
                keep = 1'b0;    // master nack ends the read
            bit_cnt++;
        end
    end

    always @(negedge scl)
    begin
        if (active && bit_cnt == 8)
        begin
            if (sending)
                drive_low = 1'b0;
            else
                take_byte();
        end
        else if (active && bit_cnt == 9)
        begin
            bit_cnt   = 0;
            active    = keep;
            sending   = send_next;
            tx        = mem[ptr];
            drive_low = active && sending && !tx[7];
        end
        else if (active && sending && bit_cnt > 0)
            drive_low = !tx[7 - bit_cnt];
    end

endmodule

//--- logic/eeprom_ctrl_top.sv
`timescale 1ns/10ps

module eeprom_ctrl_top
    import i2c_line_pkg::*;
    import eeprom_host_pkg::*;
(
    input  logic    CLK,
    input  logic    RESET,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output logic    scl,
    inout  wire     sda
);

    logic     cmd_valid;
    bit_cmd_t cmd;
    logic     done;
    bit_rsp_t rsp;
    logic     sda_low;
    logic     sda_in;

    eeprom_seq u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .done      (done),
        .rsp       (rsp)
    );

    i2c_bit_engine u_bits (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .done      (done),
        .rsp       (rsp),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

    // open drain, pull-up sits outside
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

//--- logic/eeprom_host_pkg.sv
package eeprom_host_pkg;

    // 24C16 style geometry, 2 KB
    localparam int EE_ADDR_W = 11;
    localparam int EE_DATA_W = 8;
    localparam int EE_SIZE   = 2 ** EE_ADDR_W;

    localparam logic [3:0] EE_DEV_TYPE = 4'b1010;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [EE_ADDR_W-1:0] adr;
        logic [EE_DATA_W-1:0] dat;
    } wb_req_t;

    // slave to master, ack and err never together
    typedef struct packed {
        logic                 ack;
        logic                 err;
        logic [EE_DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage

//--- logic/eeprom_seq.sv
`timescale 1ns/10ps

module eeprom_seq
    import i2c_line_pkg::*;
    import eeprom_host_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output logic     cmd_valid,
    output bit_cmd_t cmd,
    input  logic     done,
    input  bit_rsp_t rsp
);

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        WDATA,
        RESTART,
        CTRL_R,
        RDATA,
        STOP,
        RESPOND
    } state_t;

    state_t               state;
    state_t               state_d;
    wb_req_t              req_q;
    logic [EE_DATA_W-1:0] rd_data_q;
    logic                 err_q;
    logic                 nack;
    logic                 resp_now;

    // one command per state, built from the latched request
    function automatic bit_cmd_t cmd_for(state_t s, wb_req_t r);
        bit_cmd_t  c;
        i2c_byte_u ctrl;
        ctrl.ctrl.dev_type = EE_DEV_TYPE;
        ctrl.ctrl.block    = r.adr[EE_ADDR_W-1:8];
        ctrl.ctrl.rw       = (s == CTRL_R);
        c.op      = OP_WRITE_BYTE;
        c.data    = ctrl.raw;
        c.ack_out = 1'b1;   // single byte read ends with nack
        case (s)
            START, RESTART: c.op = OP_START;
            STOP: c.op = OP_STOP;
            ADDR: c.data = r.adr[7:0];
            WDATA: c.data = r.dat;
            RDATA: c.op = OP_READ_BYTE;
            default: c.op = OP_WRITE_BYTE;
        endcase
        return c;
    endfunction

    // slave refused a byte we sent
    assign nack = done && rsp.ack_in &&
                  (state == CTRL_W || state == ADDR || state == WDATA || state == CTRL_R);

    always_comb
    begin
        state_d = state;
        case (state)
            IDLE:
            begin
                if (wb_req.cyc && wb_req.stb)
                    state_d = START;
            end
            START: if (done) state_d = CTRL_W;
            CTRL_W: if (done) state_d = nack ? STOP : ADDR;
            ADDR:
            begin
                if (done)
                begin
                    if (nack)
                        state_d = STOP;
                    else
                        state_d = req_q.we ? WDATA : RESTART;
                end
            end
            WDATA: if (done) state_d = STOP;
            RESTART: if (done) state_d = CTRL_R;
            CTRL_R: if (done) state_d = nack ? STOP : RDATA;
            RDATA: if (done) state_d = STOP;
            STOP: if (done) state_d = RESPOND;
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            err_q     <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            state     <= state_d;
            cmd_valid <= (state_d != state) && (state_d != IDLE) && (state_d != RESPOND);
            if (state == IDLE)
                err_q <= 1'b0;
            else if (nack)
                err_q <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE)
            req_q <= wb_req;    // master holds it until ack or err
        if (state_d != state)
            cmd <= cmd_for(state_d, req_q);
        if (state == RDATA && done)
            rd_data_q <= rsp.data;
    end

    assign resp_now = (state == RESPOND) && wb_req.cyc && wb_req.stb;

    always_comb
    begin
        wb_rsp.ack = resp_now && !err_q;
        wb_rsp.err = resp_now && err_q;
        wb_rsp.dat = rd_data_q;
    end

endmodule

//--- logic/i2c_bit_engine.sv
`timescale 1ns/10ps

module i2c_bit_engine
    import i2c_line_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_valid,
    input  bit_cmd_t cmd,
    output logic     done,
    output bit_rsp_t rsp,
    output logic     scl,
    output logic     sda_low,
    input  logic     sda_in
);

    logic              busy;
    bit_op_e           op_q;
    logic [7:0]        shift_q;
    logic              ack_out_q;
    logic [QCNT_W-1:0] qcnt;
    logic [1:0]        phase;       // quarter within the bit
    logic [3:0]        bit_cnt;     // 0..7 data, 8 acknowledge
    logic              quarter_end;
    logic              is_byte;
    logic              last_quarter;

    assign quarter_end  = (qcnt == QCNT_W'(QUARTER_CYCLES - 1));
    assign is_byte      = (op_q == OP_WRITE_BYTE) || (op_q == OP_READ_BYTE);
    assign last_quarter = quarter_end && (phase == 2'd3) && (!is_byte || bit_cnt == 4'd8);

    // line levels on entry to a quarter, {scl, sda_low}
    function automatic logic [1:0] phase_drive(bit_op_e op, logic [1:0] ph, logic [3:0] bitn,
                                               logic tx_bit, logic ack_lvl, logic sda_now);
        logic [1:0] lines;
        lines = {1'b0, sda_now};
        case (op)
            OP_START:
            begin
                case (ph)
                    2'd0: lines = 2'b00;
                    2'd1: lines = 2'b10;
                    2'd2: lines = 2'b11;    // sda falls, scl high
                    default: lines = 2'b01;
                endcase
            end
            OP_STOP:
            begin
                case (ph)
                    2'd0: lines = 2'b01;
                    2'd1: lines = 2'b11;
                    default: lines = 2'b10; // sda released, scl high
                endcase
            end
            OP_WRITE_BYTE, OP_READ_BYTE:
            begin
                if (ph == 2'd0)
                begin
                    // data only changes here, scl low
                    if (bitn == 4'd8)
                        lines = {1'b0, (op == OP_READ_BYTE) ? ~ack_lvl : 1'b0};
                    else
                        lines = {1'b0, (op == OP_WRITE_BYTE) ? ~tx_bit : 1'b0};
                end
                else
                    lines = {ph[1], sda_now};
            end
            default: lines = {1'b0, sda_now};
        endcase
        return lines;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            qcnt    <= '0;
            phase   <= 2'd0;
            bit_cnt <= 4'd0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (cmd_valid)
                begin
                    busy    <= 1'b1;
                    qcnt    <= '0;
                    phase   <= 2'd0;
                    bit_cnt <= 4'd0;
                    {scl, sda_low} <= phase_drive(cmd.op, 2'd0, 4'd0, cmd.data[7],
                                                  cmd.ack_out, sda_low);
                end
            end
            else if (quarter_end)
            begin
                qcnt <= '0;
                if (last_quarter)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    if (is_byte)
                        scl <= 1'b0;    // low until the next command
                end
                else if (phase == 2'd3)
                begin
                    phase   <= 2'd0;
                    bit_cnt <= bit_cnt + 4'd1;
                    {scl, sda_low} <= phase_drive(op_q, 2'd0, bit_cnt + 4'd1, shift_q[7],
                                                  ack_out_q, sda_low);
                end
                else
                begin
                    phase <= phase + 2'd1;
                    {scl, sda_low} <= phase_drive(op_q, phase + 2'd1, bit_cnt, shift_q[7],
                                                  ack_out_q, sda_low);
                end
            end
            else
                qcnt <= qcnt + QCNT_W'(1);
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && cmd_valid)
        begin
            op_q      <= cmd.op;
            shift_q   <= {cmd.data[6:0], 1'b0};    // msb already on the line
            ack_out_q <= cmd.ack_out;
        end
        else if (busy && quarter_end && phase == 2'd3)
            shift_q <= {shift_q[6:0], 1'b0};

        // middle of the high phase
        if (busy && is_byte && quarter_end && phase == 2'd2)
        begin
            if (bit_cnt == 4'd8)
                rsp.ack_in <= sda_in;
            else
                rsp.data <= {rsp.data[6:0], sda_in};
        end
    end

endmodule

//--- logic/i2c_line_pkg.sv
package i2c_line_pkg;

    // CLK cycles per quarter of an SCL period, one bit is four quarters
    localparam int QUARTER_CYCLES = 2;
    localparam int QCNT_W = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE_BYTE,
        OP_READ_BYTE
    } bit_op_e;

    typedef struct packed {
        bit_op_e    op;
        logic [7:0] data;       // byte to send
        logic       ack_out;    // level driven after a read byte, 1 = nack
    } bit_cmd_t;

    typedef struct packed {
        logic [7:0] data;       // received byte
        logic       ack_in;     // sampled after a written byte, 0 = ack
    } bit_rsp_t;

    // control byte as sent on the wire, msb first
    typedef struct packed {
        logic [3:0] dev_type;
        logic [2:0] block;      // address bits 10..8
        logic       rw;         // 1 = read
    } ctrl_fields_t;

    typedef union packed {
        logic [7:0]   raw;
        ctrl_fields_t ctrl;
    } i2c_byte_u;

endpackage
